// File: Bender.yml
package:
  name: vex_execute_stage

export_include_dirs:
  - .

sources:
  - vex_pkg.sv
  - vex_lane_alu.sv
  - vex_result_unit.sv
  - vex_execute_stage.sv
  - target: test
    files:
      - tb_vex_execute_stage.sv

// File: filelist.f
+incdir+.
vex_pkg.sv
vex_lane_alu.sv
vex_result_unit.sv
vex_execute_stage.sv
tb_vex_execute_stage.sv

// File: tb_vex_execute_stage.sv
/*
 * directed tests for the two-lane execute stage, expected values from a local model
 * inputs change 2 ns after the rising edge, outputs are sampled 1 ns after it
 */
`timescale 1ns/1ns
`default_nettype none
`include "vex_macros.svh"

module tb_vex_execute_stage
  import vex_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 8;

  logic                   CLK;
  logic                   nRST;
  logic                   in_valid;
  logic                   in_first;
  logic                   stall;
  logic                   flush;
  vex_kind_t              kind;
  vex_aluop_t             aluop;
  vex_minmax_t            minmax;
  vex_sew_t               sew;
  vex_mask_op_t           mask_op;
  logic                   reduce;
  vex_src_t               rs1_src;
  vex_src_t               rs2_src;
  logic [`VEX_WORD_W-1:0] vs1_lane0;
  logic [`VEX_WORD_W-1:0] vs1_lane1;
  logic [`VEX_WORD_W-1:0] vs2_lane0;
  logic [`VEX_WORD_W-1:0] vs2_lane1;
  logic [`VEX_WORD_W-1:0] imm;
  logic [`VEX_WORD_W-1:0] xs1;
  logic [`VEX_WORD_W-1:0] xs2;
  logic [`VEX_VREG_W-1:0] vd;
  logic [`VEX_WEN_W-1:0]  wen;
  logic                   out_valid;
  logic [`VEX_WORD_W-1:0] result0;
  logic [`VEX_WORD_W-1:0] result1;
  logic [`VEX_VREG_W-1:0] out_vd;
  logic [`VEX_WEN_W-1:0]  out_wen;

  integer seed = 32'h59ad_4c66;
  integer error_count = 0;
  integer check_count = 0;
  integer test_count = 0;
  // model copy of the first-set found flag
  logic   model_found = 1'b0;

  vex_execute_stage u_vex_execute_stage (
    .CLK       (CLK),
    .nRST      (nRST),
    .in_valid  (in_valid),
    .in_first  (in_first),
    .stall     (stall),
    .flush     (flush),
    .kind      (kind),
    .aluop     (aluop),
    .minmax    (minmax),
    .sew       (sew),
    .mask_op   (mask_op),
    .reduce    (reduce),
    .rs1_src   (rs1_src),
    .rs2_src   (rs2_src),
    .vs1_lane0 (vs1_lane0),
    .vs1_lane1 (vs1_lane1),
    .vs2_lane0 (vs2_lane0),
    .vs2_lane1 (vs2_lane1),
    .imm       (imm),
    .xs1       (xs1),
    .xs2       (xs2),
    .vd        (vd),
    .wen       (wen),
    .out_valid (out_valid),
    .result0   (result0),
    .result1   (result1),
    .out_vd    (out_vd),
    .out_wen   (out_wen)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count = check_count + 1;
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
      error_count = error_count + 1;
    end
  endtask

  task automatic report_test(input string name, input integer errs_before);
    test_count = test_count + 1;
    if (error_count == errs_before) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: %0d error(s)", name, error_count - errs_before);
    end
  endtask

  // sign extends the low sew bits, then flips the msb so an unsigned compare orders them
  function automatic logic [31:0] order_key(input logic [31:0] w, input logic is_signed,
                                            input vex_sew_t s);
    logic [31:0] ext;
    case (s)
      SEW8:    ext = {{24{w[7]}}, w[7:0]};
      SEW16:   ext = {{16{w[15]}}, w[15:0]};
      default: ext = w;
    endcase
    if (is_signed) begin
      return ext ^ 32'h8000_0000;
    end else begin
      return w;
    end
  endfunction

  function automatic logic [31:0] alu_model(input vex_aluop_t op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic        is_signed;
    logic [31:0] ka;
    logic [31:0] kb;
    is_signed = (minmax == MIN) || (minmax == MAX);
    ka = order_key(a, is_signed, sew);
    kb = order_key(b, is_signed, sew);
    case (op)
      VALU_ADD:  alu_model = a + b;
      VALU_AND:  alu_model = a & b;
      VALU_OR:   alu_model = a | b;
      VALU_XOR:  alu_model = a ^ b;
      VALU_MM: begin
        // equal keys keep operand a
        if (minmax == MIN || minmax == MINU) begin
          alu_model = (kb < ka) ? b : a;
        end else begin
          alu_model = (ka < kb) ? b : a;
        end
      end
      VALU_MOVE: alu_model = b;
      default:   alu_model = '0;
    endcase
  endfunction

  function automatic logic [31:0] expected_lane(input logic [31:0] v1, input logic [31:0] v2);
    logic [31:0] a;
    logic [31:0] b;
    case (rs1_src)
      SRC_I:   a = imm;
      SRC_X:   a = xs1;
      default: a = v1;
    endcase
    case (rs2_src)
      SRC_I:   b = imm;
      SRC_X:   b = xs2;
      default: b = v2;
    endcase
    return alu_model(aluop, a, b);
  endfunction

  // walks the 64 mask bits from lane 0 bit 0 upward
  task automatic mask_model(input vex_mask_op_t op, input logic first, input logic [31:0] m0,
                            input logic [31:0] m1, output logic [31:0] e0,
                            output logic [31:0] e1);
    logic [63:0] bits;
    logic [63:0] res;
    integer      i;
    bits = {m1, m0};
    res = '0;
    if (first) begin
      model_found = 1'b0;
    end
    for (i = 0; i < 64; i++) begin
      if (!model_found) begin
        if (bits[i]) begin
          model_found = 1'b1;
          res[i] = (op != MASK_SBF);
        end else begin
          res[i] = (op != MASK_SOF);
        end
      end
    end
    e0 = res[31:0];
    e1 = res[63:32];
  endtask

  task automatic randomize_data();
    vs1_lane0 = $random(seed);
    vs1_lane1 = $random(seed);
    vs2_lane0 = $random(seed);
    vs2_lane1 = $random(seed);
    imm = $random(seed);
    xs1 = $random(seed);
    xs2 = $random(seed);
    vd = $random(seed);
    wen = $random(seed);
  endtask

  task automatic idle_inputs();
    in_valid = 1'b0;
    in_first = 1'b0;
  endtask

  task automatic check_outputs_zero();
    check_value("out_valid", out_valid, 0);
    check_value("out_wen", out_wen, 0);
    check_value("out_vd", out_vd, 0);
    check_value("result0", result0, 0);
    check_value("result1", result1, 0);
  endtask

  task automatic wait_for_valid(output logic seen);
    integer cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      #1;
      cycles = cycles + 1;
      if (out_valid) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      $display("timeout at %0t ns: out_valid did not rise after a strobe", $time);
      error_count = error_count + 1;
    end else if (cycles != 1) begin
      $display("at %0t ns out_valid rose %0d cycles after the strobe instead of one",
               $time, cycles);
      error_count = error_count + 1;
    end
  endtask

  // leaves in_valid high so the caller can follow with another beat
  task automatic issue_beat(input logic [31:0] exp0, input logic [31:0] exp1);
    logic [`VEX_VREG_W-1:0] exp_vd;
    logic [`VEX_WEN_W-1:0]  exp_wen;
    logic                   seen;
    vd = $random(seed);
    wen = $random(seed);
    exp_vd = vd;
    exp_wen = wen;
    in_valid = 1'b1;
    wait_for_valid(seen);
    if (seen) begin
      check_value("result0", result0, exp0);
      check_value("result1", result1, exp1);
      check_value("out_vd", out_vd, exp_vd);
      check_value("out_wen", out_wen, exp_wen);
    end
    #1;
  endtask

  task automatic test_reset();
    integer errs;
    errs = error_count;
    nRST = 1'b0;
    #2;
    randomize_data();
    repeat (2) begin
      @(posedge CLK);
      #1;
      check_outputs_zero();
    end
    #1;
    nRST = 1'b1;
    model_found = 1'b0;
    repeat (2) begin
      @(posedge CLK);
      #1;
      check_outputs_zero();
      #1;
      randomize_data();
    end
    report_test("reset", errs);
  endtask

  task automatic test_alu_sources();
    integer errs;
    integer op;
    integer s1;
    integer s2;
    errs = error_count;
    kind = ALU;
    reduce = 1'b0;
    for (op = 0; op < 6; op++) begin
      for (s1 = 0; s1 < 3; s1++) begin
        for (s2 = 0; s2 < 3; s2++) begin
          randomize_data();
          aluop = vex_aluop_t'(op);
          rs1_src = vex_src_t'(s1);
          rs2_src = vex_src_t'(s2);
          minmax = vex_minmax_t'($random(seed) & 3);
          sew = vex_sew_t'(($random(seed) & 3) % 3);
          issue_beat(expected_lane(vs1_lane0, vs2_lane0),
                     expected_lane(vs1_lane1, vs2_lane1));
        end
      end
    end
    idle_inputs();
    // out_valid drops once the strobes stop
    @(posedge CLK);
    #1;
    check_value("out_valid", out_valid, 0);
    #1;
    report_test("alu_sources", errs);
  endtask

  task automatic test_minmax();
    integer      errs;
    integer      s;
    integer      m;
    logic [31:0] a;
    logic [31:0] b;
    errs = error_count;
    kind = ALU;
    reduce = 1'b0;
    aluop = VALU_MM;
    rs1_src = SRC_V;
    rs2_src = SRC_V;
    for (s = 0; s < 3; s++) begin
      // only the signed view at the current sew ranks operand a below b
      case (s)
        0: begin
          a = 32'h0000_0080;
          b = 32'h0000_0005;
        end
        1: begin
          a = 32'h0012_8001;
          b = 32'h0000_7FFF;
        end
        default: begin
          a = 32'h8000_0005;
          b = 32'h0000_0001;
        end
      endcase
      for (m = 0; m < 4; m++) begin
        sew = vex_sew_t'(s);
        minmax = vex_minmax_t'(m);
        vs1_lane0 = a;
        vs2_lane0 = b;
        vs1_lane1 = b;
        vs2_lane1 = a;
        issue_beat(expected_lane(vs1_lane0, vs2_lane0),
                   expected_lane(vs1_lane1, vs2_lane1));
      end
    end
    idle_inputs();
    report_test("minmax", errs);
  endtask

  task automatic test_reduce();
    integer      errs;
    integer      k;
    logic [31:0] l0;
    logic [31:0] l1;
    errs = error_count;
    kind = ALU;
    reduce = 1'b1;
    rs1_src = SRC_V;
    rs2_src = SRC_V;
    minmax = MAX;
    sew = SEW32;
    for (k = 0; k < 6; k++) begin
      randomize_data();
      case (k / 2)
        0:       aluop = VALU_ADD;
        1:       aluop = VALU_XOR;
        default: aluop = VALU_MM;
      endcase
      l0 = expected_lane(vs1_lane0, vs2_lane0);
      l1 = expected_lane(vs1_lane1, vs2_lane1);
      issue_beat(alu_model(aluop, l0, l1), l1);
    end
    idle_inputs();
    reduce = 1'b0;
    report_test("reduce", errs);
  endtask

  task automatic test_mask_first();
    integer      errs;
    integer      o;
    integer      k;
    logic [31:0] exp0;
    logic [31:0] exp1;
    errs = error_count;
    kind = MASK;
    aluop = VALU_MOVE;
    rs1_src = SRC_V;
    rs2_src = SRC_V;
    for (o = 0; o < 3; o++) begin
      mask_op = vex_mask_op_t'(o);
      // the fourth beat opens a new instruction
      for (k = 0; k < 4; k++) begin
        vs1_lane0 = $random(seed);
        vs1_lane1 = $random(seed);
        in_first = (k == 0) || (k == 3);
        case (k)
          0: begin
            vs2_lane0 = '0;
            vs2_lane1 = '0;
          end
          1: begin
            vs2_lane0 = '0;
            vs2_lane1 = 32'h0F00_0100;
          end
          2: begin
            vs2_lane0 = $random(seed) | 1;
            vs2_lane1 = $random(seed);
          end
          default: begin
            vs2_lane0 = 32'h0000_0020;
            vs2_lane1 = 32'h8000_0000;
          end
        endcase
        mask_model(mask_op, in_first, vs2_lane0, vs2_lane1, exp0, exp1);
        issue_beat(exp0, exp1);
      end
    end
    idle_inputs();
    report_test("mask_first_set", errs);
  endtask

  task automatic test_stall_flush();
    integer                 errs;
    integer                 k;
    logic [31:0]            held0;
    logic [31:0]            held1;
    logic [`VEX_VREG_W-1:0] held_vd;
    logic [`VEX_WEN_W-1:0]  held_wen;
    logic [31:0]            exp0;
    logic [31:0]            exp1;
    errs = error_count;
    kind = ALU;
    reduce = 1'b0;
    aluop = VALU_ADD;
    rs1_src = SRC_V;
    rs2_src = SRC_V;
    randomize_data();
    issue_beat(expected_lane(vs1_lane0, vs2_lane0), expected_lane(vs1_lane1, vs2_lane1));
    held0 = result0;
    held1 = result1;
    held_vd = out_vd;
    held_wen = out_wen;
    idle_inputs();
    stall = 1'b1;
    for (k = 0; k < 3; k++) begin
      randomize_data();
      @(posedge CLK);
      #1;
      check_value("out_valid", out_valid, 0);
      check_value("result0", result0, held0);
      check_value("result1", result1, held1);
      check_value("out_vd", out_vd, held_vd);
      check_value("out_wen", out_wen, held_wen);
      #1;
    end
    stall = 1'b0;
    // a beat after the stall goes through normally
    randomize_data();
    issue_beat(expected_lane(vs1_lane0, vs2_lane0), expected_lane(vs1_lane1, vs2_lane1));
    kind = MASK;
    aluop = VALU_MOVE;
    mask_op = MASK_SOF;
    in_first = 1'b1;
    vs2_lane0 = 32'h0000_0100;
    vs2_lane1 = '0;
    mask_model(mask_op, in_first, vs2_lane0, vs2_lane1, exp0, exp1);
    issue_beat(exp0, exp1);
    idle_inputs();
    flush = 1'b1;
    @(posedge CLK);
    #1;
    check_outputs_zero();
    #1;
    flush = 1'b0;
    model_found = 1'b0;
    // search restarts without in_first, then stops once found
    vs2_lane0 = 32'h0000_0010;
    mask_model(mask_op, in_first, vs2_lane0, vs2_lane1, exp0, exp1);
    issue_beat(exp0, exp1);
    vs2_lane0 = 32'h0000_0001;
    mask_model(mask_op, in_first, vs2_lane0, vs2_lane1, exp0, exp1);
    issue_beat(exp0, exp1);
    idle_inputs();
    report_test("stall_flush", errs);
  endtask

  initial begin
    nRST = 1'b0;
    in_valid = 1'b0;
    in_first = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    kind = ALU;
    aluop = VALU_ADD;
    minmax = MIN;
    sew = SEW32;
    mask_op = MASK_SBF;
    reduce = 1'b0;
    rs1_src = SRC_V;
    rs2_src = SRC_V;
    vs1_lane0 = '0;
    vs1_lane1 = '0;
    vs2_lane0 = '0;
    vs2_lane1 = '0;
    imm = '0;
    xs1 = '0;
    xs2 = '0;
    vd = '0;
    wen = '0;
    test_reset();
    test_alu_sources();
    test_minmax();
    test_reduce();
    test_mask_first();
    test_stall_flush();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vex_execute_stage.sv
/*
 * two-lane vector execute stage, one cycle from strobe to output
 * on mask beats upstream sets both sources to SRC_V with VALU_MOVE
 * no back-pressure; stall comes from hazard control
 */
`timescale 1ns/1ns
`default_nettype none
`include "vex_macros.svh"

module vex_execute_stage
  import vex_pkg::*;
(
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   in_valid,
  input  logic                   in_first,
  input  logic                   stall,
  input  logic                   flush,
  input  vex_kind_t              kind,
  input  vex_aluop_t             aluop,
  input  vex_minmax_t            minmax,
  input  vex_sew_t               sew,
  input  vex_mask_op_t           mask_op,
  input  logic                   reduce,
  input  vex_src_t               rs1_src,
  input  vex_src_t               rs2_src,
  input  logic [`VEX_WORD_W-1:0] vs1_lane0,
  input  logic [`VEX_WORD_W-1:0] vs1_lane1,
  input  logic [`VEX_WORD_W-1:0] vs2_lane0,
  input  logic [`VEX_WORD_W-1:0] vs2_lane1,
  input  logic [`VEX_WORD_W-1:0] imm,
  input  logic [`VEX_WORD_W-1:0] xs1,
  input  logic [`VEX_WORD_W-1:0] xs2,
  input  logic [`VEX_VREG_W-1:0] vd,
  input  logic [`VEX_WEN_W-1:0]  wen,
  output logic                   out_valid,
  output logic [`VEX_WORD_W-1:0] result0,
  output logic [`VEX_WORD_W-1:0] result1,
  output logic [`VEX_VREG_W-1:0] out_vd,
  output logic [`VEX_WEN_W-1:0]  out_wen
);

  logic [`VEX_WORD_W-1:0] lane_result0;
  logic [`VEX_WORD_W-1:0] lane_result1;

  // scalar and immediate operands are shared by both lanes
  vex_lane_alu u_lane0 (
    .rs1_src (rs1_src),
    .rs2_src (rs2_src),
    .vs1     (vs1_lane0),
    .vs2     (vs2_lane0),
    .imm     (imm),
    .xs1     (xs1),
    .xs2     (xs2),
    .aluop   (aluop),
    .minmax  (minmax),
    .sew     (sew),
    .result  (lane_result0)
  );

  vex_lane_alu u_lane1 (
    .rs1_src (rs1_src),
    .rs2_src (rs2_src),
    .vs1     (vs1_lane1),
    .vs2     (vs2_lane1),
    .imm     (imm),
    .xs1     (xs1),
    .xs2     (xs2),
    .aluop   (aluop),
    .minmax  (minmax),
    .sew     (sew),
    .result  (lane_result1)
  );

  vex_result_unit u_result (
    .CLK          (CLK),
    .nRST         (nRST),
    .in_valid     (in_valid),
    .in_first     (in_first),
    .stall        (stall),
    .flush        (flush),
    .kind         (kind),
    .aluop        (aluop),
    .minmax       (minmax),
    .sew          (sew),
    .mask_op      (mask_op),
    .reduce       (reduce),
    .lane_result0 (lane_result0),
    .lane_result1 (lane_result1),
    .vd           (vd),
    .wen          (wen),
    .out_valid    (out_valid),
    .result0      (result0),
    .result1      (result1),
    .out_vd       (out_vd),
    .out_wen      (out_wen)
  );

endmodule

`default_nettype wire

// File: vex_lane_alu.sv
/*
 * operand select and element ALU for one lane, purely combinational
 * add, and, or, xor work on the full word regardless of sew
 */
`timescale 1ns/1ns
`default_nettype none
`include "vex_macros.svh"

module vex_lane_alu
  import vex_pkg::*;
(
  input  vex_src_t               rs1_src,
  input  vex_src_t               rs2_src,
  input  logic [`VEX_WORD_W-1:0] vs1,
  input  logic [`VEX_WORD_W-1:0] vs2,
  input  logic [`VEX_WORD_W-1:0] imm,
  input  logic [`VEX_WORD_W-1:0] xs1,
  input  logic [`VEX_WORD_W-1:0] xs2,
  input  vex_aluop_t             aluop,
  input  vex_minmax_t            minmax,
  input  vex_sew_t               sew,
  output logic [`VEX_WORD_W-1:0] result
);

  logic [`VEX_WORD_W-1:0] op_a;
  logic [`VEX_WORD_W-1:0] op_b;

  // operand a comes from vs1, the immediate or scalar rs1
  always_comb begin
    case (rs1_src)
      SRC_V: begin
        op_a = vs1;
      end
      SRC_I: begin
        op_a = imm;
      end
      SRC_X: begin
        op_a = xs1;
      end
      default: begin
        op_a = '0;
      end
    endcase
  end

  // operand b comes from vs2, the immediate or scalar rs2
  always_comb begin
    case (rs2_src)
      SRC_V: begin
        op_b = vs2;
      end
      SRC_I: begin
        op_b = imm;
      end
      SRC_X: begin
        op_b = xs2;
      end
      default: begin
        op_b = '0;
      end
    endcase
  end

  always_comb begin
    case (aluop)
      VALU_ADD: begin
        result = op_a + op_b;
      end
      VALU_AND: begin
        result = op_a & op_b;
      end
      VALU_OR: begin
        result = op_a | op_b;
      end
      VALU_XOR: begin
        result = op_a ^ op_b;
      end
      VALU_MM: begin
        result = vex_minmax(op_a, op_b, minmax, sew);
      end
      // mask beats rely on move passing vs2 straight through
      VALU_MOVE: begin
        result = op_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // reserved select and op encodings would silently yield zero
  a_legal_encoding: assert final (
    $isunknown({rs1_src, rs2_src, aluop})
    || ((rs1_src inside {SRC_V, SRC_I, SRC_X})
        && (rs2_src inside {SRC_V, SRC_I, SRC_X})
        && (aluop inside {VALU_ADD, VALU_AND, VALU_OR, VALU_XOR, VALU_MM, VALU_MOVE}))
  );

endmodule

`default_nettype wire

// File: vex_macros.svh
/*
 * widths shared by the execute stage RTL and its testbench
 * the element word is fixed at 32 bits and the lane count at two
 */
`ifndef VEX_MACROS_SVH
`define VEX_MACROS_SVH

// one lane element word
`define VEX_WORD_W 32

// destination vector register number
`define VEX_VREG_W 5

// one write enable bit per lane
`define VEX_WEN_W 2

`endif

// File: vex_pkg.sv
/*
 * types and helpers shared by the execute stage and its testbench
 * signed min/max only looks at the low sew bits of each element word
 * ties in min/max keep operand a
 */
`default_nettype none
`include "vex_macros.svh"

package vex_pkg;

  typedef enum logic {
    ALU,
    MASK
  } vex_kind_t;

  typedef enum logic [2:0] {
    VALU_ADD  = 3'd0,
    VALU_AND  = 3'd1,
    VALU_OR   = 3'd2,
    VALU_XOR  = 3'd3,
    VALU_MM   = 3'd4,
    VALU_MOVE = 3'd5
  } vex_aluop_t;

  typedef enum logic [1:0] {
    MIN,
    MINU,
    MAX,
    MAXU
  } vex_minmax_t;

  typedef enum logic [1:0] {
    SRC_V,
    SRC_I,
    SRC_X
  } vex_src_t;

  typedef enum logic [1:0] {
    SEW8,
    SEW16,
    SEW32
  } vex_sew_t;

  typedef enum logic [1:0] {
    MASK_SBF,
    MASK_SIF,
    MASK_SOF
  } vex_mask_op_t;

  // one element word seen at three element widths
  typedef union packed {
    logic [`VEX_WORD_W-1:0]           w;
    logic [1:0][`VEX_WORD_W/2-1:0]    h;
    logic [3:0][`VEX_WORD_W/4-1:0]    b;
  } vex_word_u;

  // signed a < b on the low sew bits, sign extended to a full word
  function automatic logic vex_sew_lt(
    input logic [`VEX_WORD_W-1:0] a,
    input logic [`VEX_WORD_W-1:0] b,
    input vex_sew_t               sew
  );
    vex_word_u                     ua;
    vex_word_u                     ub;
    logic signed [`VEX_WORD_W-1:0] sa;
    logic signed [`VEX_WORD_W-1:0] sb;
    ua = a;
    ub = b;
    case (sew)
      SEW8: begin
        sa = $signed(ua.b[0]);
        sb = $signed(ub.b[0]);
      end
      SEW16: begin
        sa = $signed(ua.h[0]);
        sb = $signed(ub.h[0]);
      end
      default: begin
        sa = $signed(ua.w);
        sb = $signed(ub.w);
      end
    endcase
    return sa < sb;
  endfunction

  // returns the whole word of the winning operand
  function automatic logic [`VEX_WORD_W-1:0] vex_minmax(
    input logic [`VEX_WORD_W-1:0] a,
    input logic [`VEX_WORD_W-1:0] b,
    input vex_minmax_t            minmax,
    input vex_sew_t               sew
  );
    logic signed_cmp;
    logic a_lt_b;
    logic b_lt_a;
    signed_cmp = (minmax == MIN) || (minmax == MAX);
    a_lt_b = signed_cmp ? vex_sew_lt(a, b, sew) : (a < b);
    b_lt_a = signed_cmp ? vex_sew_lt(b, a, sew) : (b < a);
    case (minmax)
      MIN, MINU: return b_lt_a ? b : a;
      default:   return a_lt_b ? b : a;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: vex_result_unit.sv
/*
 * reduction, first-set mask logic and the stage output latch
 * upstream must not strobe in_valid during stall; flush wins over stall
 * mask beats expect each lane result to carry its raw vs2 mask word
 */
`timescale 1ns/1ns
`default_nettype none
`include "vex_macros.svh"

module vex_result_unit
  import vex_pkg::*;
(
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   in_valid,
  input  logic                   in_first,
  input  logic                   stall,
  input  logic                   flush,
  input  vex_kind_t              kind,
  input  vex_aluop_t             aluop,
  input  vex_minmax_t            minmax,
  input  vex_sew_t               sew,
  input  vex_mask_op_t           mask_op,
  input  logic                   reduce,
  input  logic [`VEX_WORD_W-1:0] lane_result0,
  input  logic [`VEX_WORD_W-1:0] lane_result1,
  input  logic [`VEX_VREG_W-1:0] vd,
  input  logic [`VEX_WEN_W-1:0]  wen,
  output logic                   out_valid,
  output logic [`VEX_WORD_W-1:0] result0,
  output logic [`VEX_WORD_W-1:0] result1,
  output logic [`VEX_VREG_W-1:0] out_vd,
  output logic [`VEX_WEN_W-1:0]  out_wen
);

  logic                         accept;
  logic                         found;
  logic                         search_found;
  logic [2*`VEX_WORD_W-1:0]     mask_bits;
  logic [2*`VEX_WORD_W-1:0]     first_bit;
  logic [2*`VEX_WORD_W-1:0]     mask_result;
  logic [`VEX_WORD_W-1:0]       red_result;
  logic [`VEX_WORD_W-1:0]       next_result0;
  logic [`VEX_WORD_W-1:0]       next_result1;

  assign accept = in_valid && !stall;

  // a new instruction searches from scratch
  assign search_found = found && !in_first;

  // lane 0 holds the low 32 mask bits
  assign mask_bits = {lane_result1, lane_result0};

  // isolate the lowest set bit, zero when no bit is set
  assign first_bit = mask_bits & (~mask_bits + 1'b1);

  // with no set bit, first_bit - 1 is all ones, as SBF and SIF need
  always_comb begin
    mask_result = '0;
    if (!search_found) begin
      case (mask_op)
        MASK_SBF: begin
          mask_result = first_bit - 1'b1;
        end
        MASK_SIF: begin
          mask_result = (first_bit - 1'b1) | first_bit;
        end
        MASK_SOF: begin
          mask_result = first_bit;
        end
        default: begin
          mask_result = '0;
        end
      endcase
    end
  end

  // lane 0 is operand a, lane 1 operand b, same as within a lane
  always_comb begin
    case (aluop)
      VALU_ADD: begin
        red_result = lane_result0 + lane_result1;
      end
      VALU_AND: begin
        red_result = lane_result0 & lane_result1;
      end
      VALU_OR: begin
        red_result = lane_result0 | lane_result1;
      end
      VALU_XOR: begin
        red_result = lane_result0 ^ lane_result1;
      end
      VALU_MM: begin
        red_result = vex_minmax(lane_result0, lane_result1, minmax, sew);
      end
      VALU_MOVE: begin
        red_result = lane_result1;
      end
      default: begin
        red_result = '0;
      end
    endcase
  end

  always_comb begin
    if (kind == MASK) begin
      next_result0 = mask_result[`VEX_WORD_W-1:0];
      next_result1 = mask_result[2*`VEX_WORD_W-1:`VEX_WORD_W];
    end else if (reduce) begin
      next_result0 = red_result;
      next_result1 = lane_result1;
    end else begin
      next_result0 = lane_result0;
      next_result1 = lane_result1;
    end
  end

  // stage latch toward memory/writeback
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      result0   <= '0;
      result1   <= '0;
      out_vd    <= '0;
      out_wen   <= '0;
    end else if (flush) begin
      out_valid <= 1'b0;
      result0   <= '0;
      result1   <= '0;
      out_vd    <= '0;
      out_wen   <= '0;
    end else if (stall) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        result0 <= next_result0;
        result1 <= next_result1;
        out_vd  <= vd;
        out_wen <= wen;
      end
    end
  end

  // first set bit seen somewhere in the current instruction
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      found <= 1'b0;
    end else if (flush) begin
      found <= 1'b0;
    end else if (accept) begin
      if (kind == MASK) begin
        found <= search_found || (mask_bits != '0);
      end else if (in_first) begin
        found <= 1'b0;
      end
    end
  end

  // hazard logic must hold off new beats while the stage is stalled
  a_no_strobe_in_stall: assert property (
    @(posedge CLK) disable iff (!nRST)
    stall |-> !in_valid
  );

  // the mask logic reads raw vs2 words, so lanes must pass them through
  a_mask_beat_is_move: assert property (
    @(posedge CLK) disable iff (!nRST)
    (in_valid && kind == MASK) |-> (aluop == VALU_MOVE)
  );

endmodule

`default_nettype wire
